// ==== cache.f ====
+incdir+include
design/cache_pkg.sv
design/meta_array.sv
design/line_array.sv
design/cache_datapath.sv
design/cache_control.sv
design/cache.sv
tb/pmem_model.sv
tb/cache_tb.sv

// ==== design/cache.sv ====
// cache top joins the controller FSM and the datapath of the two-way write-back cache
`timescale 1ns/1ps

module cache
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  mem_read,
    input  logic  mem_write,
    input  word_t mem_address,
    input  line_t mem_wdata256,
    input  mask_t mem_byte_enable256,
    output line_t mem_rdata256,
    output logic  mem_resp,
    input  line_t pmem_rdata,
    input  logic  pmem_resp,
    output logic  pmem_read,
    output logic  pmem_write,
    output word_t pmem_address,
    output line_t pmem_wdata
);

    logic hit;
    logic dirty;
    logic load_tag;
    logic set_valid;
    logic set_dirty;
    logic reset_dirty;
    logic set_lru;
    logic load_data;
    logic pmem_write_sel;

    cache_control u_control (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .pmem_resp      (pmem_resp),
        .hit            (hit),
        .dirty          (dirty),
        .mem_resp       (mem_resp),
        .pmem_read      (pmem_read),
        .pmem_write     (pmem_write),
        .load_tag       (load_tag),
        .set_valid      (set_valid),
        .set_dirty      (set_dirty),
        .reset_dirty    (reset_dirty),
        .set_lru        (set_lru),
        .load_data      (load_data),
        .pmem_write_sel (pmem_write_sel)
    );

    cache_datapath u_datapath (
        .clk                (clk),
        .rst_n              (rst_n),
        .mem_address        (mem_address),
        .mem_wdata256       (mem_wdata256),
        .mem_byte_enable256 (mem_byte_enable256),
        .pmem_rdata         (pmem_rdata),
        .load_tag           (load_tag),
        .set_valid          (set_valid),
        .set_dirty          (set_dirty),
        .reset_dirty        (reset_dirty),
        .set_lru            (set_lru),
        .load_data          (load_data),
        .pmem_write_sel     (pmem_write_sel),
        .hit                (hit),
        .dirty              (dirty),
        .mem_rdata256       (mem_rdata256),
        .pmem_wdata         (pmem_wdata),
        .pmem_address       (pmem_address)
    );

endmodule

// ==== design/cache_control.sv ====
// cache_control sequences hit service, dirty write-back and line fill
`timescale 1ns/1ps

module cache_control
    import cache_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic mem_read,
    input  logic mem_write,
    input  logic pmem_resp,
    input  logic hit,
    input  logic dirty,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write,
    output logic load_tag,
    output logic set_valid,
    output logic set_dirty,
    output logic reset_dirty,
    output logic set_lru,
    output logic load_data,
    output logic pmem_write_sel
);

    cache_state_t state;
    cache_state_t next_state;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= s_idle_check;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state     = state;
        mem_resp       = 1'b0;
        pmem_read      = 1'b0;
        pmem_write     = 1'b0;
        load_tag       = 1'b0;
        set_valid      = 1'b0;
        set_dirty      = 1'b0;
        reset_dirty    = 1'b0;
        set_lru        = 1'b0;
        load_data      = 1'b0;
        pmem_write_sel = 1'b0;

        unique case (state)
            s_idle_check:
            begin
                if (mem_read || mem_write)
                begin
                    if (hit)
                    begin
                        mem_resp = 1'b1;
                        set_lru  = 1'b1;
                        if (mem_write)
                        begin
                            set_dirty = 1'b1; // merge lands at this edge
                            load_data = 1'b1;
                        end
                    end
                    else if (dirty)
                        next_state = s_writeback;
                    else
                        next_state = s_fill;
                end
            end
            s_writeback:
            begin
                pmem_write     = 1'b1;
                pmem_write_sel = 1'b1; // address from victim tag
                if (pmem_resp)
                    next_state = s_fill;
            end
            s_fill:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    load_data   = 1'b1;
                    load_tag    = 1'b1;
                    set_valid   = 1'b1;
                    reset_dirty = 1'b1;
                    next_state  = s_idle_check; // retry now hits
                end
            end
            default: next_state = s_idle_check;
        endcase
    end

    a_pmem_one_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        !(pmem_read && pmem_write));

    a_resp_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_resp) |-> (mem_read || mem_write));

endmodule

// ==== design/cache_datapath.sv ====
// cache_datapath does tag compare, way select and owns the tag, state and line arrays
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_datapath
    import cache_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  word_t mem_address,
    input  line_t mem_wdata256,
    input  mask_t mem_byte_enable256,
    input  line_t pmem_rdata,
    input  logic  load_tag,
    input  logic  set_valid,
    input  logic  set_dirty,
    input  logic  reset_dirty,
    input  logic  set_lru,
    input  logic  load_data,
    input  logic  pmem_write_sel,
    output logic  hit,
    output logic  dirty,
    output line_t mem_rdata256,
    output line_t pmem_wdata,
    output word_t pmem_address
);

    tag_t   addr_tag;
    index_t addr_index;

    tag_t        way_tag [2];
    line_t       way_data [2];
    mask_t       way_we [2];
    logic [1:0]  way_valid;
    logic [1:0]  way_dirty;
    logic [1:0]  way_hit;
    logic [1:0]  is_victim;

    logic  lru_out; // way to replace next
    logic  fill;
    logic  write_hit;
    line_t line_in;
    tag_t  victim_tag;

    assign addr_tag   = mem_address[$bits(word_t)-1 -: `CACHE_TAG_BITS];
    assign addr_index = mem_address[`CACHE_OFFSET_BITS +: `CACHE_INDEX_BITS];

    assign fill      = load_data && !set_dirty;
    assign write_hit = load_data && set_dirty;
    assign line_in   = fill ? pmem_rdata : mem_wdata256;

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        assign is_victim[w] = (lru_out == 1'(w));
        assign way_hit[w]   = way_valid[w] && (way_tag[w] == addr_tag);

        // fill takes the whole victim line, a write hit only the enabled bytes
        assign way_we[w] = (fill && is_victim[w])   ? '1 :
                           (write_hit && way_hit[w]) ? mem_byte_enable256 : '0;

        line_array u_data (
            .clk      (clk),
            .rst_n    (rst_n),
            .write_en (way_we[w]),
            .index    (addr_index),
            .datain   (line_in),
            .dataout  (way_data[w])
        );

        meta_array #(.width(`CACHE_TAG_BITS)) u_tag (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (load_tag && is_victim[w]),
            .rindex  (addr_index),
            .windex  (addr_index),
            .datain  (addr_tag),
            .dataout (way_tag[w])
        );

        meta_array #(.width(1)) u_valid (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (set_valid && is_victim[w]),
            .rindex  (addr_index),
            .windex  (addr_index),
            .datain  (1'b1),
            .dataout (way_valid[w])
        );

        meta_array #(.width(1)) u_dirty (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    ((set_dirty && way_hit[w]) || (reset_dirty && is_victim[w])),
            .rindex  (addr_index),
            .windex  (addr_index),
            .datain  (set_dirty),
            .dataout (way_dirty[w])
        );
    end

    // next victim is the way not hit
    meta_array #(.width(1)) u_lru (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (set_lru),
        .rindex  (addr_index),
        .windex  (addr_index),
        .datain  (way_hit[0]),
        .dataout (lru_out)
    );

    assign hit   = |way_hit;
    assign dirty = way_dirty[lru_out];

    assign victim_tag   = way_tag[lru_out];
    assign pmem_wdata   = way_data[lru_out];
    assign mem_rdata256 = way_data[way_hit[1]];

    assign pmem_address = pmem_write_sel ?
                          {victim_tag, addr_index, {`CACHE_OFFSET_BITS{1'b0}}} :
                          {addr_tag, addr_index, {`CACHE_OFFSET_BITS{1'b0}}};

    // a tag may live in only one way of a set
    a_single_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(way_hit));

endmodule

// ==== design/cache_pkg.sv ====
// cache_pkg holds the vector types and controller states shared by the cache blocks
`include "cache_cfg.svh"

package cache_pkg;

    localparam int line_bytes = 1 << `CACHE_OFFSET_BITS; // bytes per line

    typedef logic [31:0] word_t; // byte address
    typedef logic [8*line_bytes-1:0] line_t;
    typedef logic [line_bytes-1:0] mask_t; // one bit per line byte

    typedef logic [`CACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`CACHE_INDEX_BITS-1:0] index_t;

    // controller states
    typedef enum logic [1:0] {
        s_idle_check,
        s_writeback,
        s_fill
    } cache_state_t;

endpackage

// ==== design/line_array.sv ====
// line_array stores one 256-bit line per set with a byte-masked write
`timescale 1ns/1ps
`include "cache_cfg.svh"

module line_array
    import cache_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  mask_t  write_en,
    input  index_t index,
    input  line_t  datain,
    output line_t  dataout
);

    line_t lines [`CACHE_SETS];

    // no writes land while reset is held
    always_ff @(posedge clk)
    begin
        if (rst_n)
        begin
            for (int i = 0; i < line_bytes; i++)
            begin
                if (write_en[i])
                begin
                    lines[index][8*i +: 8] <= datain[8*i +: 8];
                end
            end
        end
    end

    assign dataout = lines[index];

endmodule

// ==== design/meta_array.sv ====
// meta_array keeps one register per set for tag, valid, dirty or LRU state
`timescale 1ns/1ps
`include "cache_cfg.svh"

module meta_array
    import cache_pkg::*;
#(
    parameter int width = 1
)
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load,
    input  index_t           rindex,
    input  index_t           windex,
    input  logic [width-1:0] datain,
    output logic [width-1:0] dataout
);

    logic [width-1:0] regs [`CACHE_SETS];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CACHE_SETS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (load)
        begin
            regs[windex] <= datain;
        end
    end

    assign dataout = regs[rindex]; // read is combinational

endmodule

// ==== include/cache_cfg.svh ====
// cache geometry and address split for the two-way line cache
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// byte offset within a 32-byte line
`define CACHE_OFFSET_BITS 5

// set index for 8 sets
`define CACHE_INDEX_BITS 3

// what is left of a 32-bit address
`define CACHE_TAG_BITS 24

`define CACHE_SETS 8 // must equal 2**CACHE_INDEX_BITS

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# compile the cache testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cache_tb -f cache.f &&
    ./obj_dir/Vcache_tb | tee sim.log
grep -q "^Simulation PASSED$" sim.log && exit 0 || exit 1

// ==== tb/cache_tb.sv ====
// cache_tb drives the two-way cache against a shadow memory and a delayed line memory
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tb
    import cache_pkg::*;
;

    localparam int num_random   = 200;
    localparam int num_requests = 14 + num_random; // directed requests plus the random mix
    localparam int watchdog_ns  = num_requests * 40 * 4;

    logic  clk;
    logic  rst_n;
    logic  mem_read;
    logic  mem_write;
    word_t mem_address;
    line_t mem_wdata256;
    mask_t mem_byte_enable256;
    line_t mem_rdata256;
    logic  mem_resp;
    line_t pmem_rdata;
    logic  pmem_resp;
    logic  pmem_read;
    logic  pmem_write;
    word_t pmem_address;
    line_t pmem_wdata;
    int    read_count;
    int    write_count;

    line_t shadow [256];
    line_t exp_line;
    string test_name;
    int    seed;
    int    cmp_errors;
    int    chk_errors;
    int    errors_at_start;
    int    pass_count;
    int    fail_count;

    cache u_dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .mem_read           (mem_read),
        .mem_write          (mem_write),
        .mem_address        (mem_address),
        .mem_wdata256       (mem_wdata256),
        .mem_byte_enable256 (mem_byte_enable256),
        .mem_rdata256       (mem_rdata256),
        .mem_resp           (mem_resp),
        .pmem_rdata         (pmem_rdata),
        .pmem_resp          (pmem_resp),
        .pmem_read          (pmem_read),
        .pmem_write         (pmem_write),
        .pmem_address       (pmem_address),
        .pmem_wdata         (pmem_wdata)
    );

    pmem_model #(.lines(256), .delay(3)) u_pmem (
        .clk         (clk),
        .rst_n       (rst_n),
        .read        (pmem_read),
        .write       (pmem_write),
        .address     (pmem_address),
        .wdata       (pmem_wdata),
        .rdata       (pmem_rdata),
        .resp        (pmem_resp),
        .read_count  (read_count),
        .write_count (write_count)
    );

    always #2 clk = ~clk;

    function automatic word_t line_addr(input int tag, input int set);
        return (word_t'(tag) << 8) | (word_t'(set) << `CACHE_OFFSET_BITS);
    endfunction

    // expected line for one access with writes merged into the shadow by byte
    function automatic line_t ref_access(input word_t addr, input logic wr,
                                         input line_t wdata, input mask_t be);
        logic [7:0] idx;
        idx = addr[`CACHE_OFFSET_BITS +: 8];
        if (wr)
        begin
            for (int b = 0; b < 32; b++)
            begin
                if (be[b])
                    shadow[idx][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return shadow[idx];
    endfunction

    // starts and ends 1 ns after a rising edge
    task automatic issue_request(input logic wr, input word_t addr,
                                 input line_t wdata, input mask_t be);
        exp_line           = ref_access(addr, wr, wdata, be);
        mem_address        = addr;
        mem_wdata256       = wdata;
        mem_byte_enable256 = be;
        mem_read           = !wr;
        mem_write          = wr;
        @(negedge clk);
        while (!mem_resp)
            @(negedge clk);
        @(posedge clk);
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = cmp_errors + chk_errors - errors_at_start;
        if (errs == 0)
        begin
            pass_count++;
            $display("test %s: pass", name);
        end
        else
        begin
            fail_count++;
            $display("test %s: fail with %0d errors", name, errs);
        end
        errors_at_start = cmp_errors + chk_errors;
    endtask

    // read data checked at each read response
    always @(negedge clk)
    begin
        if (rst_n && mem_resp && mem_read)
        begin
            if (mem_rdata256 !== exp_line)
            begin
                $display("mismatch %s expected %h actual %h", test_name, exp_line, mem_rdata256);
                cmp_errors++;
            end
        end
    end

    initial
    begin
        #(watchdog_ns);
        $display("error: run timed out after %0d ns in test %s", watchdog_ns, test_name);
        $display("Simulation FAILED");
        $finish;
    end

    initial
    begin
        word_t a;
        word_t b;
        word_t c;
        line_t wdata;
        mask_t be;
        int    r;
        int    cnt;
        clk = 1'b0;
        rst_n = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_address = '0;
        mem_wdata256 = '0;
        mem_byte_enable256 = '0;
        exp_line = '0;
        seed = 72;
        cmp_errors = 0;
        chk_errors = 0;
        errors_at_start = 0;
        pass_count = 0;
        fail_count = 0;
        test_name = "reset_idle";
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < 256; i++)
            shadow[i] = u_pmem.mem[i];

        repeat (8)
        begin
            @(negedge clk);
            if (mem_resp || pmem_read || pmem_write)
            begin
                $display("error: reset_idle saw activity with no request pending");
                chk_errors++;
            end
        end
        @(posedge clk);
        #1;
        finish_test(test_name);

        test_name = "read_miss_then_hit";
        a = line_addr(0, 0);
        issue_request(1'b0, a, '0, '0);
        cnt = read_count;
        issue_request(1'b0, a, '0, '0);
        if (read_count != cnt)
        begin
            $display("mismatch %s expected %0d actual %0d", test_name, cnt, read_count);
            chk_errors++;
        end
        finish_test(test_name);

        test_name = "masked_write_hit";
        for (int w = 0; w < 8; w++)
            wdata[32*w +: 32] = $random(seed);
        issue_request(1'b1, a, wdata, 32'h0f0f_00ff);
        issue_request(1'b0, a, '0, '0);
        if (read_count != cnt)
        begin
            $display("mismatch %s expected %0d actual %0d", test_name, cnt, read_count);
            chk_errors++;
        end
        finish_test(test_name);

        test_name = "lru_order";
        a = line_addr(1, 2);
        b = line_addr(2, 2);
        c = line_addr(3, 2);
        issue_request(1'b0, a, '0, '0);
        issue_request(1'b0, b, '0, '0);
        issue_request(1'b0, a, '0, '0);
        issue_request(1'b0, c, '0, '0); // B is the victim
        cnt = read_count;
        issue_request(1'b0, a, '0, '0);
        if (read_count != cnt)
        begin
            $display("mismatch %s expected %0d actual %0d", test_name, cnt, read_count);
            chk_errors++;
        end
        issue_request(1'b0, b, '0, '0);
        if (read_count != cnt + 1)
        begin
            $display("mismatch %s expected %0d actual %0d", test_name, cnt + 1, read_count);
            chk_errors++;
        end
        finish_test(test_name);

        test_name = "dirty_eviction";
        a = line_addr(5, 4);
        b = line_addr(6, 4);
        c = line_addr(7, 4);
        for (int w = 0; w < 8; w++)
            wdata[32*w +: 32] = $random(seed);
        issue_request(1'b1, a, wdata, 32'hff00_f0f0);
        issue_request(1'b0, b, '0, '0);
        cnt = write_count;
        issue_request(1'b0, c, '0, '0); // evicts the dirty A
        if (write_count != cnt + 1)
        begin
            $display("mismatch %s expected %0d actual %0d", test_name, cnt + 1, write_count);
            chk_errors++;
        end
        if (u_pmem.mem[a[`CACHE_OFFSET_BITS +: 8]] !== shadow[a[`CACHE_OFFSET_BITS +: 8]])
        begin
            $display("mismatch %s expected %h actual %h", test_name,
                     shadow[a[`CACHE_OFFSET_BITS +: 8]], u_pmem.mem[a[`CACHE_OFFSET_BITS +: 8]]);
            chk_errors++;
        end
        issue_request(1'b0, a, '0, '0);
        finish_test(test_name);

        test_name = "random_mix";
        for (int n = 0; n < num_random; n++)
        begin
            r = $random(seed);
            for (int w = 0; w < 8; w++)
                wdata[32*w +: 32] = $random(seed);
            be = $random(seed);
            a = line_addr(r & 15, ((r >> 4) & 1) != 0 ? 3 : 1); // 16 tags in sets 1 and 3
            issue_request(r[5], a, wdata, be);
        end
        finish_test(test_name);

        $display("tests %0d passed %0d failed %0d errors %0d", pass_count + fail_count,
                 pass_count, fail_count, cmp_errors + chk_errors);
        if (fail_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== tb/pmem_model.sv ====
// pmem_model is a line-wide backing memory that answers after a fixed delay
`timescale 1ns/1ps
`include "cache_cfg.svh"

module pmem_model
    import cache_pkg::*;
#(
    parameter int lines = 256,
    parameter int delay = 3
)
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  read,
    input  logic  write,
    input  word_t address,
    input  line_t wdata,
    output line_t rdata,
    output logic  resp,
    output int    read_count,
    output int    write_count
);

    line_t mem [lines];
    int    wait_cnt;
    logic [$clog2(lines)-1:0] line_idx;

    assign line_idx = address[`CACHE_OFFSET_BITS +: $clog2(lines)];

    // every 32-bit word gets a value from its own word address
    initial
    begin
        for (int i = 0; i < lines; i++)
        begin
            for (int w = 0; w < 8; w++)
            begin
                mem[i][32*w +: 32] = 32'(i*8 + w) * 32'h9e37_79b1 ^ 32'h5a3c_0f00;
            end
        end
    end

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            resp        <= 1'b0;
            wait_cnt    <= 0;
            read_count  <= 0;
            write_count <= 0;
        end
        else
        begin
            resp <= 1'b0;
            if ((read || write) && !resp) // resp cycle ends the request
            begin
                if (wait_cnt == delay - 1)
                begin
                    wait_cnt <= 0;
                    resp     <= 1'b1;
                    if (write)
                    begin
                        mem[line_idx] <= wdata;
                        write_count   <= write_count + 1;
                    end
                    else
                    begin
                        rdata      <= mem[line_idx];
                        read_count <= read_count + 1;
                    end
                end
                else
                    wait_cnt <= wait_cnt + 1;
            end
        end
    end

endmodule
